// ==== vlog.f ====
+incdir+common
common/flash_cmd_pkg.sv
common/flash_bus_pkg.sv
source/bus_phase_timer.sv
source/buffer_port.sv
op_sequencer/op_sequencer.sv
source/flash_bus_controller.sv
testbench/tb_clock.sv
testbench/nand_model.sv
testbench/tb_flash_bus_controller.sv

// ==== Bender.yml ====
package:
  name: flash_bus_controller

sources:
  - include_dirs:
      - common
    files:
      - common/flash_cmd_pkg.sv
      - common/flash_bus_pkg.sv
      - source/bus_phase_timer.sv
      - source/buffer_port.sv
      - op_sequencer/op_sequencer.sv
      - source/flash_bus_controller.sv

  - target: test
    include_dirs:
      - common
    files:
      - testbench/tb_clock.sv
      - testbench/nand_model.sv
      - testbench/tb_flash_bus_controller.sv

// ==== testbench/tb_flash_bus_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flash_settings.svh"

module tb_flash_bus_controller;

	localparam int MAX_BYTES = 16;
	localparam int LOG_MAX   = 32;
	localparam int SLACK     = 16;   // Handshake and gap cycles per operation

	logic                             clk;
	logic                             rst;
	logic                             start;
	flash_bus_pkg::flash_req_t        req;
	logic                             busy;
	logic [`FLASH_NUM_CHIPS-1:0]      chip_ready;
	logic [`FLASH_NUM_CHIPS-1:0]      chip_result;
	logic [7:0]                       bus_data;
	flash_bus_pkg::nand_pins_t        bus;
	logic [`FLASH_BUF_ADDR_WIDTH-1:0] wr_buf_addr;
	logic [15:0]                      wr_buf_data;
	flash_bus_pkg::rd_buf_t           rd_buf;
	logic [7:0]                       status;

	logic [15:0]                 wr_mem [0:(1 << `FLASH_BUF_ADDR_WIDTH)-1];
	logic [7:0]                  page_mem [0:MAX_BYTES-1];
	logic [7:0]                  exp_byte [0:LOG_MAX-1];
	logic                        exp_cle  [0:LOG_MAX-1];
	logic                        exp_ale  [0:LOG_MAX-1];
	logic [15:0]                 exp_words [0:MAX_BYTES/2-1];
	int                          exp_cnt;
	int                          exp_nwords;
	logic [`FLASH_NUM_CHIPS-1:0] exp_ready;
	logic [`FLASH_NUM_CHIPS-1:0] exp_result;
	logic [31:0]                 lfsr_state;
	int                          value_errors;
	int                          other_errors;
	int                          cycle_cnt;
	int                          cycle_budget;
	int                          log_base;
	int                          rd_base;
	int                          rd_words_seen;
	int                          we_low;
	int                          re_low;

	tb_clock u_clock (.o_clk(clk), .o_rst(rst));

	nand_model u_nand (.i_bus(bus), .i_status(status), .o_data(bus_data));

	flash_bus_controller i_flash_bus_controller (
		.i_clk         (clk),
		.i_rst         (rst),
		.i_start       (start),
		.i_req         (req),
		.o_busy        (busy),
		.o_chip_ready  (chip_ready),
		.o_chip_result (chip_result),
		.i_bus_data    (bus_data),
		.o_bus         (bus),
		.o_wr_buf_addr (wr_buf_addr),
		.i_wr_buf_data (wr_buf_data),
		.o_rd_buf      (rd_buf)
	);

	always @(posedge clk) wr_buf_data <= wr_mem[wr_buf_addr];  // One-cycle buffer read

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	function automatic flash_bus_pkg::flash_req_t make_request(input flash_cmd_pkg::flash_op_e op);
		flash_bus_pkg::flash_req_t r;
		logic [31:0]               lo;
		logic [31:0]               hi;
		logic [31:0]               chip;
		logic [31:0]               len;
		lo       = rand_bits(32);
		hi       = rand_bits(8);
		chip     = rand_bits(`FLASH_CHIP_BITS);
		len      = rand_bits(3);
		r.op     = op;
		r.chip   = chip[`FLASH_CHIP_BITS-1:0];
		r.addr   = {hi[7:0], lo};
		r.length = `FLASH_LENGTH_WIDTH'(2 * (len + 1));  // Even, 2 to 16 bytes
		return r;
	endfunction

	function automatic int op_cycles(input flash_bus_pkg::flash_req_t r);
		int wc;
		int rc;
		wc = `FLASH_T_WC + 1;   // One idle cycle between phases
		rc = `FLASH_T_RC + 1;
		case (r.op)
			flash_cmd_pkg::OP_READSTATUS: return wc + `FLASH_T_WHR + rc + `FLASH_T_RHW + SLACK;
			flash_cmd_pkg::OP_RESET:      return wc + `FLASH_T_WB + SLACK;
			flash_cmd_pkg::OP_ERASE:      return 5 * wc + `FLASH_T_WB + SLACK;
			flash_cmd_pkg::OP_PROGRAM:    return (7 + r.length) * wc + `FLASH_T_ADL + `FLASH_T_WB + SLACK;
			flash_cmd_pkg::OP_STARTREAD:  return 7 * wc + `FLASH_T_WB + SLACK;
			default:                      return wc + `FLASH_T_WHR + r.length * rc + `FLASH_T_RHW + SLACK;
		endcase
	endfunction

	function automatic void add_cycle(input logic cle, input logic ale, input logic [7:0] b);
		exp_byte[exp_cnt] = b;
		exp_cle[exp_cnt]  = cle;
		exp_ale[exp_cnt]  = ale;
		exp_cnt           = exp_cnt + 1;
	endfunction

	// Expected bus cycles, read buffer words and chip bits of one request
	function automatic void build_expected(input flash_bus_pkg::flash_req_t r, input logic [7:0] st);
		logic [39:0] a;
		logic [15:0] w;
		a          = r.addr;
		exp_cnt    = 0;
		exp_nwords = 0;
		if (r.op != flash_cmd_pkg::OP_READSTATUS && r.op != flash_cmd_pkg::OP_COMPLETEREAD)
			exp_ready[r.chip] = 1'b0;   // Chip turns busy until the next status read
		case (r.op)
			flash_cmd_pkg::OP_READSTATUS: begin
				add_cycle(1'b1, 1'b0, 8'h70);
				exp_ready[r.chip]  = st[6];
				exp_result[r.chip] = st[0];
			end
			flash_cmd_pkg::OP_RESET: add_cycle(1'b1, 1'b0, 8'hFF);
			flash_cmd_pkg::OP_ERASE: begin
				add_cycle(1'b1, 1'b0, 8'h60);
				for (int i = 0; i < 3; i++)
					add_cycle(1'b0, 1'b1, a[16 + 8*i +: 8]);   // Row only
				add_cycle(1'b1, 1'b0, 8'hD0);
			end
			flash_cmd_pkg::OP_PROGRAM, flash_cmd_pkg::OP_STARTREAD: begin
				add_cycle(1'b1, 1'b0, (r.op == flash_cmd_pkg::OP_PROGRAM) ? 8'h80 : 8'h00);
				for (int i = 0; i < 5; i++)
					add_cycle(1'b0, 1'b1, a[8*i +: 8]);
				for (int i = 0; i < r.length && r.op == flash_cmd_pkg::OP_PROGRAM; i++) begin
					w = wr_mem[i / 2];
					add_cycle(1'b0, 1'b0, (i % 2 == 0) ? w[15:8] : w[7:0]);
				end
				add_cycle(1'b1, 1'b0, (r.op == flash_cmd_pkg::OP_PROGRAM) ? 8'h10 : 8'h30);
			end
			default: begin
				add_cycle(1'b1, 1'b0, 8'h00);
				exp_nwords = r.length / 2;
				for (int i = 0; i < exp_nwords; i++)
					exp_words[i] = {page_mem[2*i], page_mem[2*i + 1]};
			end
		endcase
	endfunction

	task automatic check_byte(input string name, input flash_cmd_pkg::nand_cmd_e exp,
			input flash_cmd_pkg::nand_cmd_e act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected %02h, actual %02h", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected %04h, actual %04h", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_chip_bits(input string name, input logic [`FLASH_NUM_CHIPS-1:0] exp,
			input logic [`FLASH_NUM_CHIPS-1:0] act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected %b, actual %b", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected %b, actual %b", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_results(input string name, input flash_bus_pkg::flash_req_t r);
		int                          n;
		logic [`FLASH_NUM_CHIPS-1:0] ces;
		n = u_nand.log_cnt - log_base;
		for (int c = 0; c < `FLASH_NUM_CHIPS; c++)
			ces[c] = (c != r.chip);   // Only the addressed chip enabled, active low
		check_count({name, " bus cycles"}, exp_cnt, n);
		for (int k = 0; k < exp_cnt && k < n; k++) begin
			check_byte($sformatf("%s cycle %0d byte", name, k),
				flash_cmd_pkg::nand_cmd_e'(exp_byte[k]),
				flash_cmd_pkg::nand_cmd_e'(u_nand.log_byte[log_base + k]));
			check_flag($sformatf("%s cycle %0d cle", name, k), exp_cle[k], u_nand.log_cle[log_base + k]);
			check_flag($sformatf("%s cycle %0d ale", name, k), exp_ale[k], u_nand.log_ale[log_base + k]);
			check_chip_bits($sformatf("%s cycle %0d ces_n", name, k), ces, u_nand.log_ces[log_base + k]);
		end
		check_count({name, " read buffer words"}, exp_nwords, rd_words_seen - rd_base);
		check_chip_bits({name, " ready"}, exp_ready, chip_ready);
		check_chip_bits({name, " result"}, exp_result, chip_result);
	endtask

	task automatic run_op(input string name, input flash_bus_pkg::flash_req_t r,
			input logic [7:0] st, input logic hold_start);
		flash_bus_pkg::flash_req_t other;
		other        = r;
		other.op     = flash_cmd_pkg::OP_RESET;
		other.chip   = r.chip + 1'b1;
		cycle_budget = cycle_budget + op_cycles(r);
		build_expected(r, st);
		log_base = u_nand.log_cnt;
		rd_base  = rd_words_seen;
		@(posedge clk);
		req    <= r;
		status <= st;
		start  <= 1'b1;
		do @(posedge clk); while (!busy);
		if (hold_start) begin
			req <= other;   // Start stays high with a new request, must be ignored
			repeat (6) @(posedge clk);
		end
		start <= 1'b0;
		do @(posedge clk); while (busy);
		if (hold_start) begin
			repeat (4) @(posedge clk);
			check_flag({name, " busy after ignored start"}, 1'b0, busy);
		end
		check_results(name, r);
	endtask

	// Read buffer writes against the expected words
	always @(posedge clk) begin
		if (!rst && rd_buf.we) begin
			if (rd_words_seen - rd_base < exp_nwords) begin
				check_count("read buffer address", rd_words_seen - rd_base, rd_buf.addr);
				check_word($sformatf("read buffer word %0d", rd_words_seen - rd_base),
					exp_words[rd_words_seen - rd_base], rd_buf.data);
			end else begin
				$display("Unexpected read buffer write at address %0d", rd_buf.addr);
				other_errors++;
			end
			rd_words_seen++;
		end
	end

	// Strobe widths and cle/ale placement
	always @(posedge clk) begin
		if (rst) begin
			we_low = 0;
			re_low = 0;
		end else begin
			if (!bus.we_n) begin
				we_low++;
			end else if (we_low != 0) begin
				check_count("we_n low pulse", `FLASH_T_WP, we_low);
				we_low = 0;
			end
			if (!bus.re_n) begin
				re_low++;
			end else if (re_low != 0) begin
				check_count("re_n low pulse", `FLASH_T_RP, re_low);
				re_low = 0;
			end
			if (bus.cle && bus.ale) begin
				$display("cle and ale were high in the same cycle");
				other_errors++;
			end
			if ((bus.cle || bus.ale) && (bus.tri_n || bus.ces_n == '1)) begin
				$display("cle or ale was high outside a write phase");
				other_errors++;
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > 2 * cycle_budget) begin
			$display("Timeout after %0d cycles, the DUT did not finish", cycle_cnt);
			$display("** FAIL **");
			$finish;
		end
	end

	initial begin
		flash_bus_pkg::flash_req_t r;
		logic [31:0]               st;
		logic [31:0]               key;
		lfsr_state    = 32'h1791_f5ef;
		start         = 1'b0;
		req           = '0;
		status        = 8'h00;
		wr_buf_data   = 16'h0000;
		exp_ready     = '0;
		exp_result    = '0;
		value_errors  = 0;
		other_errors  = 0;
		cycle_cnt     = 0;
		cycle_budget  = 2 * SLACK;
		rd_words_seen = 0;
		log_base      = 0;
		rd_base       = 0;
		exp_nwords    = 0;
		do @(posedge clk); while (rst);

		check_flag("reset busy", 1'b0, busy);
		check_flag("reset we_n", 1'b1, bus.we_n);
		check_flag("reset re_n", 1'b1, bus.re_n);
		check_flag("reset tri_n", 1'b1, bus.tri_n);
		check_flag("reset cle", 1'b0, bus.cle);
		check_flag("reset ale", 1'b0, bus.ale);
		check_flag("reset read buffer we", 1'b0, rd_buf.we);
		check_chip_bits("reset ces_n", '1, bus.ces_n);
		check_chip_bits("reset ready", '0, chip_ready);
		check_chip_bits("reset result", '0, chip_result);
		check_count("reset bus cycles", 0, u_nand.log_cnt);

		for (int c = 0; c < `FLASH_NUM_CHIPS; c++) begin
			r      = make_request(flash_cmd_pkg::OP_READSTATUS);
			r.chip = c[`FLASH_CHIP_BITS-1:0];
			st     = rand_bits(8);
			st[6]  = ~c[0];   // Even chips report ready, odd chips busy
			run_op($sformatf("status chip %0d", c), r, st[7:0], 1'b0);
		end

		for (int t = 0; t < 2; t++) begin
			key = rand_bits(16);
			for (int a = 0; a < (1 << `FLASH_BUF_ADDR_WIDTH); a++)
				wr_mem[a] = 16'(a * 40503) ^ key[15:0];   // Odd multiplier spreads every address bit
			r      = make_request(flash_cmd_pkg::OP_PROGRAM);
			r.chip = `FLASH_CHIP_BITS'(2 * t);   // A ready chip, so the clear is visible
			run_op($sformatf("program %0d", t), r, 8'h00, t[0]);   // Second one also tries a start while busy
		end

		run_op("erase", make_request(flash_cmd_pkg::OP_ERASE), 8'h00, 1'b0);
		run_op("reset", make_request(flash_cmd_pkg::OP_RESET), 8'h00, 1'b0);
		run_op("start read", make_request(flash_cmd_pkg::OP_STARTREAD), 8'h00, 1'b0);

		for (int t = 0; t < 2; t++) begin
			for (int i = 0; i < MAX_BYTES; i++) begin
				st            = rand_bits(8);
				page_mem[i]   = st[7:0];
				u_nand.page[i] = st[7:0];
			end
			r = make_request(flash_cmd_pkg::OP_COMPLETEREAD);
			run_op($sformatf("complete read %0d", t), r, 8'h00, 1'b0);
		end

		repeat (4) @(posedge clk);
		$display("Errors: %0d wrong value, %0d other", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/nand_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flash_settings.svh"

module nand_model (
	input  wire flash_bus_pkg::nand_pins_t i_bus,
	input  wire logic [7:0]                i_status,
	output logic [7:0]                     o_data
);

	localparam int LOG_DEPTH  = 512;
	localparam int PAGE_BYTES = 256;

	// One entry per latched write cycle, cle and ale tell command, address or data
	logic [7:0]                  log_byte [0:LOG_DEPTH-1];
	logic                        log_cle  [0:LOG_DEPTH-1];
	logic                        log_ale  [0:LOG_DEPTH-1];
	logic [`FLASH_NUM_CHIPS-1:0] log_ces  [0:LOG_DEPTH-1];
	int                          log_cnt;

	logic [7:0] page [0:PAGE_BYTES-1];  // Loaded by the testbench before a read
	logic       status_mode;            // Reads return status after 70h
	int         page_idx;
	logic       we_n;
	logic       re_n;

	assign we_n = i_bus.we_n;
	assign re_n = i_bus.re_n;

	initial begin
		log_cnt     = 0;
		status_mode = 1'b0;
		page_idx    = 0;
		o_data      = 8'h00;
	end

	// Latch on the WE# rising edge, skipped while no chip is enabled
	always @(posedge we_n) begin
		if (i_bus.ces_n != '1 && log_cnt < LOG_DEPTH) begin
			log_byte[log_cnt] = i_bus.data;
			log_cle[log_cnt]  = i_bus.cle;
			log_ale[log_cnt]  = i_bus.ale;
			log_ces[log_cnt]  = i_bus.ces_n;
			log_cnt           = log_cnt + 1;
			if (i_bus.cle && i_bus.data == 8'h70) begin
				status_mode = 1'b1;
			end else if (i_bus.cle && i_bus.data == 8'h00) begin
				status_mode = 1'b0;   // Back to page data, from the first byte
				page_idx    = 0;
			end
		end
	end

	// Next byte goes out as RE# falls
	always @(negedge re_n) begin
		if (status_mode) begin
			o_data = i_status;
		end else begin
			o_data   = page[page_idx % PAGE_BYTES];
			page_idx = page_idx + 1;
		end
	end

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter real PERIOD_NS    = 20.0,
	parameter int  RESET_CYCLES = 2
) (
	output logic o_clk,
	output logic o_rst
);

	initial begin
		o_clk = 1'b0;
		forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
	end

	// Reset released on a rising edge
	initial begin
		o_rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clk);
		o_rst <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== source/flash_bus_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flash_settings.svh"

module flash_bus_controller (
	input  wire logic                              i_clk,
	input  wire logic                              i_rst,

	// Host side
	input  wire logic                              i_start,
	input  wire flash_bus_pkg::flash_req_t         i_req,
	output logic                                   o_busy,
	output logic [`FLASH_NUM_CHIPS-1:0]            o_chip_ready,
	output logic [`FLASH_NUM_CHIPS-1:0]            o_chip_result,

	// NAND bus
	input  wire logic [7:0]                        i_bus_data,
	output flash_bus_pkg::nand_pins_t              o_bus,

	// Page buffers
	output logic [`FLASH_BUF_ADDR_WIDTH-1:0]       o_wr_buf_addr,
	input  wire logic [15:0]                       i_wr_buf_data,
	output flash_bus_pkg::rd_buf_t                 o_rd_buf
);

	logic                       phase_start;
	flash_bus_pkg::phase_req_t  phase;
	logic                       phase_done;
	logic [7:0]                 rd_byte;
	logic [7:0]                 wr_byte;
	flash_bus_pkg::buf_ctl_t    buf_ctl;

	op_sequencer u_seq (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_start       (i_start),
		.i_req         (i_req),
		.o_busy        (o_busy),
		.i_phase_done  (phase_done),
		.i_rd_byte     (rd_byte),
		.i_wr_byte     (wr_byte),
		.o_phase_start (phase_start),
		.o_phase       (phase),
		.o_buf_ctl     (buf_ctl),
		.o_chip_ready  (o_chip_ready),
		.o_chip_result (o_chip_result)
	);

	bus_phase_timer u_timer (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_phase_start (phase_start),
		.i_phase       (phase),
		.i_bus_data    (i_bus_data),
		.o_phase_done  (phase_done),
		.o_rd_byte     (rd_byte),
		.o_bus         (o_bus)
	);

	buffer_port u_buf (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_buf_ctl     (buf_ctl),
		.i_rd_byte     (rd_byte),
		.o_wr_byte     (wr_byte),
		.o_wr_buf_addr (o_wr_buf_addr),
		.i_wr_buf_data (i_wr_buf_data),
		.o_rd_buf      (o_rd_buf)
	);

endmodule

`default_nettype wire

// ==== op_sequencer/op_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flash_settings.svh"

module op_sequencer (
	input  wire logic                          i_clk,
	input  wire logic                          i_rst,
	input  wire logic                          i_start,
	input  wire flash_bus_pkg::flash_req_t     i_req,
	output logic                               o_busy,
	input  wire logic                          i_phase_done,
	input  wire logic [7:0]                    i_rd_byte,
	input  wire logic [7:0]                    i_wr_byte,
	output logic                               o_phase_start,
	output flash_bus_pkg::phase_req_t          o_phase,
	output flash_bus_pkg::buf_ctl_t            o_buf_ctl,
	output logic [`FLASH_NUM_CHIPS-1:0]        o_chip_ready,
	output logic [`FLASH_NUM_CHIPS-1:0]        o_chip_result
);

	localparam logic [`FLASH_TIMER_WIDTH-1:0] WAIT_WHR = `FLASH_T_WHR;
	localparam logic [`FLASH_TIMER_WIDTH-1:0] WAIT_ADL = `FLASH_T_ADL;
	localparam logic [`FLASH_TIMER_WIDTH-1:0] WAIT_RHW = `FLASH_T_RHW;
	localparam logic [`FLASH_TIMER_WIDTH-1:0] WAIT_WB  = `FLASH_T_WB;
	localparam logic [`FLASH_LENGTH_WIDTH-1:0] STATUS_LEN = 1;

	// Steps shared by all operations, each one bus phase
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_CMD0,
		ST_ADDR,
		ST_WAIT_PRE,   // WHR before reads, ADL before program data
		ST_WDATA,
		ST_RDATA,
		ST_CMD1,
		ST_WAIT_POST   // RHW after reads, WB after busy-causing commands
	} step_e;

	step_e                               step;
	logic                                running;   // Phase ordered, done not seen yet
	flash_bus_pkg::flash_req_t           req_q;
	logic [2:0]                          addr_idx;
	logic [2:0]                          addr_last;
	logic [`FLASH_LENGTH_WIDTH-1:0]      byte_cnt;
	logic [`FLASH_NUM_CHIPS-1:0]         ready_q;
	logic [`FLASH_NUM_CHIPS-1:0]         result_q;
	logic [7:0]                          addr_byte;
	flash_cmd_pkg::nand_cmd_e            cmd0;
	flash_cmd_pkg::nand_cmd_e            cmd1;
	logic                                is_read_op;
	logic                                accept;

	assign accept     = (step == ST_IDLE) && i_start;
	assign is_read_op = (req_q.op == flash_cmd_pkg::OP_READSTATUS) ||
	                    (req_q.op == flash_cmd_pkg::OP_COMPLETEREAD);
	assign addr_last  = (req_q.op == flash_cmd_pkg::OP_ERASE) ? 3'd2 : 3'd4;

	// Erase walks the row view, page operations the byte view
	assign addr_byte = (req_q.op == flash_cmd_pkg::OP_ERASE) ?
	                   req_q.addr.rowcol.row[8*addr_idx +: 8] : req_q.addr.bytes[addr_idx];

	always_comb begin
		case (req_q.op)
			flash_cmd_pkg::OP_READSTATUS: cmd0 = flash_cmd_pkg::CMD_STATUS;
			flash_cmd_pkg::OP_RESET:      cmd0 = flash_cmd_pkg::CMD_RESET;
			flash_cmd_pkg::OP_ERASE:      cmd0 = flash_cmd_pkg::CMD_ERASE0;
			flash_cmd_pkg::OP_PROGRAM:    cmd0 = flash_cmd_pkg::CMD_PROGRAM0;
			default:                      cmd0 = flash_cmd_pkg::CMD_READ0;
		endcase
		case (req_q.op)
			flash_cmd_pkg::OP_ERASE:   cmd1 = flash_cmd_pkg::CMD_ERASE1;
			flash_cmd_pkg::OP_PROGRAM: cmd1 = flash_cmd_pkg::CMD_PROGRAM1;
			default:                   cmd1 = flash_cmd_pkg::CMD_READ1;
		endcase
	end

	// Phase order for the current step
	always_comb begin
		o_phase.kind        = flash_bus_pkg::PH_IDLE;
		o_phase.byte_out    = 8'h00;
		o_phase.chip        = req_q.chip;
		o_phase.wait_cycles = WAIT_WB;
		case (step)
			ST_CMD0: begin
				o_phase.kind     = flash_bus_pkg::PH_CMD;
				o_phase.byte_out = cmd0;
			end
			ST_ADDR: begin
				o_phase.kind     = flash_bus_pkg::PH_ADDR;
				o_phase.byte_out = addr_byte;
			end
			ST_WAIT_PRE: begin
				o_phase.kind        = flash_bus_pkg::PH_WAIT;
				o_phase.wait_cycles = is_read_op ? WAIT_WHR : WAIT_ADL;
			end
			ST_WDATA: begin
				o_phase.kind     = flash_bus_pkg::PH_WDATA;
				o_phase.byte_out = i_wr_byte;
			end
			ST_RDATA: o_phase.kind = flash_bus_pkg::PH_RDATA;
			ST_CMD1: begin
				o_phase.kind     = flash_bus_pkg::PH_CMD;
				o_phase.byte_out = cmd1;
			end
			ST_WAIT_POST: begin
				o_phase.kind        = flash_bus_pkg::PH_WAIT;
				o_phase.wait_cycles = is_read_op ? WAIT_RHW : WAIT_WB;
			end
			default: ;
		endcase
	end

	assign o_phase_start = (step != ST_IDLE) && !running;
	assign o_busy        = (step != ST_IDLE);

	assign o_buf_ctl.rewind      = accept;
	assign o_buf_ctl.wr_consumed = (step == ST_WDATA) && i_phase_done;
	assign o_buf_ctl.rd_captured = (step == ST_RDATA) && i_phase_done &&
	                               (req_q.op == flash_cmd_pkg::OP_COMPLETEREAD);

	always_ff @(posedge i_clk) begin
		if (accept)
			req_q <= i_req;
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			step     <= ST_IDLE;
			running  <= 1'b0;
			addr_idx <= 3'd0;
			byte_cnt <= '0;
			ready_q  <= '0;
			result_q <= '0;
		end else if (accept) begin
			step     <= ST_CMD0;
			addr_idx <= 3'd0;
			byte_cnt <= (i_req.op == flash_cmd_pkg::OP_READSTATUS) ? STATUS_LEN : i_req.length;
			// Chip goes busy, poll status before trusting it again
			if (i_req.op != flash_cmd_pkg::OP_READSTATUS &&
			    i_req.op != flash_cmd_pkg::OP_COMPLETEREAD)
				ready_q[i_req.chip] <= 1'b0;
		end else if (o_phase_start) begin
			running <= 1'b1;
		end else if (i_phase_done) begin
			running <= 1'b0;
			case (step)
				ST_CMD0: begin
					if (req_q.op == flash_cmd_pkg::OP_RESET)
						step <= ST_WAIT_POST;
					else if (is_read_op)
						step <= ST_WAIT_PRE;
					else
						step <= ST_ADDR;
				end
				ST_ADDR: begin
					addr_idx <= addr_idx + 3'd1;
					if (addr_idx == addr_last)
						step <= (req_q.op == flash_cmd_pkg::OP_PROGRAM) ? ST_WAIT_PRE : ST_CMD1;
				end
				ST_WAIT_PRE: begin
					if (is_read_op)
						step <= (byte_cnt == '0) ? ST_WAIT_POST : ST_RDATA;
					else
						step <= (byte_cnt == '0) ? ST_CMD1 : ST_WDATA;
				end
				ST_WDATA: begin
					byte_cnt <= byte_cnt - 1'b1;
					if (byte_cnt == STATUS_LEN)
						step <= ST_CMD1;
				end
				ST_RDATA: begin
					byte_cnt <= byte_cnt - 1'b1;
					if (req_q.op == flash_cmd_pkg::OP_READSTATUS) begin
						ready_q[req_q.chip]  <= i_rd_byte[6]; // RDY
						result_q[req_q.chip] <= i_rd_byte[0]; // FAIL
					end
					if (byte_cnt == STATUS_LEN)
						step <= ST_WAIT_POST;
				end
				ST_CMD1:      step <= ST_WAIT_POST;
				ST_WAIT_POST: step <= ST_IDLE;
				default:      step <= ST_IDLE;
			endcase
		end
	end

	assign o_chip_ready  = ready_q;
	assign o_chip_result = result_q;

endmodule

`default_nettype wire

// ==== source/buffer_port.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flash_settings.svh"

module buffer_port (
	input  wire logic                            i_clk,
	input  wire logic                            i_rst,
	input  wire flash_bus_pkg::buf_ctl_t         i_buf_ctl,
	input  wire logic [7:0]                      i_rd_byte,
	output logic [7:0]                           o_wr_byte,
	output logic [`FLASH_BUF_ADDR_WIDTH-1:0]     o_wr_buf_addr,
	input  wire logic [15:0]                     i_wr_buf_data,
	output flash_bus_pkg::rd_buf_t               o_rd_buf
);

	logic [`FLASH_BUF_ADDR_WIDTH-1:0] wr_addr_q;
	logic [`FLASH_BUF_ADDR_WIDTH-1:0] rd_addr_q;
	logic                             hi_half;    // Next byte is the upper half of a word
	logic                             rd_we_q;
	logic [15:0]                      rd_word_q;
	flash_bus_pkg::wr_buf_t           wr_port;

	// Next word address goes out early to cover the one-cycle buffer read
	always_comb begin
		if (i_buf_ctl.rewind)
			wr_port.addr = '0;
		else if (i_buf_ctl.wr_consumed && !hi_half)
			wr_port.addr = wr_addr_q + 1'b1;
		else
			wr_port.addr = wr_addr_q;
		wr_port.data = i_wr_buf_data;
	end

	assign o_wr_buf_addr = wr_port.addr;
	assign o_wr_byte     = hi_half ? wr_port.data[15:8] : wr_port.data[7:0];

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			wr_addr_q <= '0;
			rd_addr_q <= '0;
			hi_half   <= 1'b1;
			rd_we_q   <= 1'b0;
		end else begin
			wr_addr_q <= wr_port.addr;
			rd_we_q   <= i_buf_ctl.rd_captured && !hi_half; // Word complete
			if (i_buf_ctl.rewind) begin
				rd_addr_q <= '0;
				hi_half   <= 1'b1;
			end else begin
				if (rd_we_q)
					rd_addr_q <= rd_addr_q + 1'b1;
				if (i_buf_ctl.wr_consumed || i_buf_ctl.rd_captured)
					hi_half <= !hi_half;
			end
		end
	end

	// High byte arrives first
	always_ff @(posedge i_clk) begin
		if (i_buf_ctl.rd_captured) begin
			if (hi_half)
				rd_word_q[15:8] <= i_rd_byte;
			else
				rd_word_q[7:0] <= i_rd_byte;
		end
	end

	assign o_rd_buf = '{addr: rd_addr_q, data: rd_word_q, we: rd_we_q};

endmodule

`default_nettype wire

// ==== source/bus_phase_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flash_settings.svh"

module bus_phase_timer (
	input  wire logic                        i_clk,
	input  wire logic                        i_rst,
	input  wire logic                        i_phase_start,
	input  wire flash_bus_pkg::phase_req_t   i_phase,
	input  wire logic [7:0]                  i_bus_data,
	output logic                             o_phase_done,
	output logic [7:0]                       o_rd_byte,
	output flash_bus_pkg::nand_pins_t        o_bus
);

	localparam int TW = `FLASH_TIMER_WIDTH;
	localparam logic [TW-1:0] LAST_WC = `FLASH_T_WC - 1;
	localparam logic [TW-1:0] LAST_RC = `FLASH_T_RC - 1;
	localparam logic [TW-1:0] WP      = `FLASH_T_WP;
	localparam logic [TW-1:0] RP      = `FLASH_T_RP;

	localparam flash_bus_pkg::nand_pins_t PINS_IDLE = '{
		data: 8'h00, tri_n: 1'b1, we_n: 1'b1, re_n: 1'b1,
		ces_n: '1, cle: 1'b0, ale: 1'b0
	};

	logic                        active;
	logic [TW-1:0]               cnt;
	logic [TW-1:0]               last_cnt;
	flash_bus_pkg::phase_req_t   cur;
	logic                        is_write;
	flash_bus_pkg::nand_pins_t   pins_d;
	flash_bus_pkg::nand_pins_t   pins_q;
	logic [7:0]                  bus_in_q;

	always_comb begin
		case (cur.kind)
			flash_bus_pkg::PH_CMD, flash_bus_pkg::PH_ADDR,
			flash_bus_pkg::PH_WDATA: last_cnt = LAST_WC;
			flash_bus_pkg::PH_RDATA: last_cnt = LAST_RC;
			flash_bus_pkg::PH_WAIT:  last_cnt = cur.wait_cycles - 1'b1;
			default:                 last_cnt = '0;
		endcase
	end

	assign o_phase_done = active && (cnt == last_cnt);

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			active <= 1'b0;
			cnt    <= '0;
		end else if (i_phase_start) begin
			active <= 1'b1;
			cnt    <= '0;
		end else if (o_phase_done) begin
			active <= 1'b0;
		end else if (active) begin
			cnt <= cnt + 1'b1;
		end
	end

	// Phase order held for the whole phase
	always_ff @(posedge i_clk) begin
		if (i_phase_start)
			cur <= i_phase;
	end

	assign is_write = (cur.kind == flash_bus_pkg::PH_CMD) ||
	                  (cur.kind == flash_bus_pkg::PH_ADDR) ||
	                  (cur.kind == flash_bus_pkg::PH_WDATA);

	always_comb begin
		pins_d = PINS_IDLE;
		if (active) begin
			pins_d.ces_n = ~({{(`FLASH_NUM_CHIPS-1){1'b0}}, 1'b1} << cur.chip);
			pins_d.cle   = (cur.kind == flash_bus_pkg::PH_CMD);
			pins_d.ale   = (cur.kind == flash_bus_pkg::PH_ADDR);
			pins_d.tri_n = !is_write;
			pins_d.data  = is_write ? cur.byte_out : 8'h00;
			pins_d.we_n  = !(is_write && cnt < WP);   // Rises mid-cycle to latch the byte
			pins_d.re_n  = !((cur.kind == flash_bus_pkg::PH_RDATA) && cnt < RP);
		end
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst)
			pins_q <= PINS_IDLE;
		else
			pins_q <= pins_d;
	end

	// Sampled while RE# is still low, seen in the last cycle of a read
	always_ff @(posedge i_clk) begin
		bus_in_q <= i_bus_data;
	end

	assign o_rd_byte = bus_in_q;
	assign o_bus     = pins_q;

endmodule

`default_nettype wire

// ==== common/flash_bus_pkg.sv ====
`default_nettype none

`include "flash_settings.svh"

package flash_bus_pkg;

	// One host request, held by the host until busy rises
	typedef struct packed {
		flash_cmd_pkg::flash_op_e         op;
		logic [`FLASH_CHIP_BITS-1:0]      chip;
		flash_cmd_pkg::flash_addr_u       addr;
		logic [`FLASH_LENGTH_WIDTH-1:0]   length;
	} flash_req_t;

	// Registered NAND bus outputs
	typedef struct packed {
		logic [7:0]                  data;
		logic                        tri_n;  // Low while the controller drives data
		logic                        we_n;
		logic                        re_n;
		logic [`FLASH_NUM_CHIPS-1:0] ces_n;
		logic                        cle;
		logic                        ale;
	} nand_pins_t;

	typedef enum logic [2:0] {
		PH_IDLE,
		PH_CMD,
		PH_ADDR,
		PH_WDATA,
		PH_RDATA,
		PH_WAIT
	} bus_phase_e;

	// One bus phase ordered by the sequencer
	typedef struct packed {
		bus_phase_e                     kind;
		logic [7:0]                     byte_out;
		logic [`FLASH_CHIP_BITS-1:0]    chip;
		logic [`FLASH_TIMER_WIDTH-1:0]  wait_cycles; // Only for PH_WAIT
	} phase_req_t;

	typedef struct packed {
		logic [`FLASH_BUF_ADDR_WIDTH-1:0] addr;
		logic [15:0]                      data;
	} wr_buf_t;

	typedef struct packed {
		logic [`FLASH_BUF_ADDR_WIDTH-1:0] addr;
		logic [15:0]                      data;
		logic                             we;
	} rd_buf_t;

	// Buffer strobes from the sequencer
	typedef struct packed {
		logic rewind;
		logic wr_consumed;
		logic rd_captured;
	} buf_ctl_t;

endpackage

`default_nettype wire

// ==== common/flash_cmd_pkg.sv ====
`default_nettype none

`include "flash_settings.svh"

package flash_cmd_pkg;

	// Operations a host can start
	typedef enum logic [2:0] {
		OP_READSTATUS   = 3'd0,
		OP_RESET        = 3'd1,
		OP_ERASE        = 3'd2,
		OP_PROGRAM      = 3'd3,
		OP_STARTREAD    = 3'd4,
		OP_COMPLETEREAD = 3'd5
	} flash_op_e;

	// Command bytes latched with CLE high
	typedef enum logic [7:0] {
		CMD_READ0       = 8'h00, // Page read setup, also read mode after a status poll
		CMD_PROGRAM1    = 8'h10,
		CMD_READ1       = 8'h30,
		CMD_ERASE0      = 8'h60,
		CMD_STATUS      = 8'h70,
		CMD_PROGRAM0    = 8'h80,
		CMD_ERASE1      = 8'hD0,
		CMD_RESET       = 8'hFF
	} nand_cmd_e;

	// Row and column halves of a full address
	typedef struct packed {
		logic [23:0] row;
		logic [15:0] col;
	} flash_rowcol_t;

	// Page operations send all five bytes, lowest first
	// Erase sends only the three row bytes
	typedef union packed {
		logic [4:0][7:0] bytes;
		flash_rowcol_t   rowcol;
	} flash_addr_u;

endpackage

`default_nettype wire

// ==== common/flash_settings.svh ====
`ifndef FLASH_SETTINGS_SVH
`define FLASH_SETTINGS_SVH

// Chips sharing the NAND bus
`define FLASH_NUM_CHIPS 4
`define FLASH_CHIP_BITS $clog2(`FLASH_NUM_CHIPS)

// Byte count of one host operation
`define FLASH_LENGTH_WIDTH 15

// Word address of the 16-bit read and write buffers
`define FLASH_BUF_ADDR_WIDTH 13

// Write cycle and WE# low time, in clocks
`define FLASH_T_WC 4
`define FLASH_T_WP 2

// Read cycle and RE# low time, in clocks
`define FLASH_T_RC 4
`define FLASH_T_RP 2

// Turnaround and busy waits, in clocks
`define FLASH_T_WHR 6
`define FLASH_T_ADL 8
`define FLASH_T_RHW 5
`define FLASH_T_WB  5

// Must hold the longest phase above
`define FLASH_TIMER_WIDTH 8

`endif
